//--- Makefile
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module cce_tb -f verilog.f -o cce_tb
	./obj_dir/cce_tb | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- hdl/cce.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE microcoded engine top level
// Fetch, decode, execute, registers,
// pending bits and message unit
////////////////////////////////////////
`include "cce_defs.svh"

module cce
  import cce_pkg::*;
  (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_run_i,
  input  logic       cfg_ucode_w_v_i,
  input  logic       cfg_ucode_r_v_i,
  input  cce_pc_t    cfg_ucode_addr_i,
  input  cce_instr_t cfg_ucode_data_i,
  output cce_instr_t cfg_ucode_data_o,
  input  logic       lce_req_v_i,
  input  cce_gpr_t   lce_req_addr_i,
  output logic       lce_req_yumi_o,
  output logic       mem_cmd_v_o,
  output cce_gpr_t   mem_cmd_addr_o,
  output cce_gpr_t   mem_cmd_data_o,
  input  logic       mem_cmd_ready_i
  );

  // Fetch to decode
  cce_instr_t   fetch_inst;
  cce_pc_t      fetch_pc;
  logic         fetch_v;

  // Decode to execute
  cce_op_e      op;
  cce_gpr_sel_t rd;
  cce_gpr_sel_t ra;
  cce_gpr_sel_t rb;
  cce_gpr_t     imm;
  cce_pc_t      ex_pc;
  logic         ex_v;

  // Execute results and control
  cce_gpr_t     alu_res;
  cce_gpr_t     opd_a;
  cce_gpr_t     opd_b;
  cce_flags_t   flags;
  logic         mispredict;
  cce_pc_t      redirect_pc;
  logic         stall;
  logic         pending;
  logic         pending_w_v;

  ////////////////////////////////////////
  // Fetch stage
  ////////////////////////////////////////
  cce_inst_ram i_inst_ram (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cfg_run_i        (cfg_run_i),
    .cfg_ucode_w_v_i  (cfg_ucode_w_v_i),
    .cfg_ucode_r_v_i  (cfg_ucode_r_v_i),
    .cfg_ucode_addr_i (cfg_ucode_addr_i),
    .cfg_ucode_data_i (cfg_ucode_data_i),
    .stall_i          (stall),
    .mispredict_i     (mispredict),
    .redirect_pc_i    (redirect_pc),
    .cfg_ucode_data_o (cfg_ucode_data_o),
    .fetch_inst_o     (fetch_inst),
    .fetch_pc_o       (fetch_pc),
    .fetch_v_o        (fetch_v)
  );

  ////////////////////////////////////////
  // Decode and execute stage
  ////////////////////////////////////////
  cce_inst_decode i_inst_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_inst_i (fetch_inst),
    .fetch_pc_i   (fetch_pc),
    .fetch_v_i    (fetch_v),
    .stall_i      (stall),
    .mispredict_i (mispredict),
    .op_o         (op),
    .rd_o         (rd),
    .ra_o         (ra),
    .rb_o         (rb),
    .imm_o        (imm),
    .ex_pc_o      (ex_pc),
    .ex_v_o       (ex_v)
  );

  cce_alu_branch i_alu_branch (
    .op_i          (op),
    .ex_v_i        (ex_v),
    .opd_a_i       (opd_a),
    .opd_b_i       (opd_b),
    .imm_i         (imm),
    .flags_i       (flags),
    .ex_pc_i       (ex_pc),
    .alu_res_o     (alu_res),
    .mispredict_o  (mispredict),
    .redirect_pc_o (redirect_pc)
  );

  cce_reg_file i_reg_file (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .op_i           (op),
    .ex_v_i         (ex_v),
    .stall_i        (stall),
    .rd_i           (rd),
    .ra_i           (ra),
    .rb_i           (rb),
    .imm_i          (imm),
    .alu_res_i      (alu_res),
    .lce_req_addr_i (lce_req_addr_i),
    .pending_i      (pending),
    .opd_a_o        (opd_a),
    .opd_b_o        (opd_b),
    .flags_o        (flags)
  );

  // WDP writes imm bit 0 to the way group in ra
  assign pending_w_v = ex_v && (op == e_op_wdp);

  cce_pending_bits i_pending_bits (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .w_v_i     (pending_w_v),
    .wg_i      (opd_a[`CCE_WG_W-1:0]),
    .pending_i (imm[0]),
    .pending_o (pending)
  );

  cce_msg i_msg (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .op_i            (op),
    .ex_v_i          (ex_v),
    .opd_a_i         (opd_a),
    .opd_b_i         (opd_b),
    .lce_req_v_i     (lce_req_v_i),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .stall_o         (stall),
    .lce_req_yumi_o  (lce_req_yumi_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_data_o  (mem_cmd_data_o)
  );

endmodule

//--- hdl/cce_alu_branch.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE ALU and branch unit
// Arithmetic, compare and flag-mask branches
////////////////////////////////////////
`include "cce_defs.svh"

module cce_alu_branch
  import cce_pkg::*;
  (
  input  cce_op_e    op_i,
  input  logic       ex_v_i,
  input  cce_gpr_t   opd_a_i,
  input  cce_gpr_t   opd_b_i,
  input  cce_gpr_t   imm_i,
  input  cce_flags_t flags_i,
  input  cce_pc_t    ex_pc_i,
  output cce_gpr_t   alu_res_o,
  output logic       mispredict_o,
  output cce_pc_t    redirect_pc_o
  );

  cce_alu_op_e alu_op;
  cce_flags_t  flag_mask;
  cce_flags_t  masked_flags;
  cce_pc_t     branch_target;
  logic        taken;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  always_comb begin
    case (op_i)
      e_op_add: alu_op = e_alu_add;
      e_op_sub: alu_op = e_alu_sub;
      default:  alu_op = e_alu_pass_b;
    endcase
  end

  always_comb begin
    case (alu_op)
      e_alu_add: alu_res_o = opd_a_i + opd_b_i;
      e_alu_sub: alu_res_o = opd_a_i - opd_b_i;
      default:   alu_res_o = opd_b_i;
    endcase
  end

  ////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////
  assign flag_mask     = imm_i[`CCE_NUM_FLAGS-1:0];
  assign masked_flags  = flags_i & flag_mask;
  assign branch_target = imm_i[`CCE_PC_W-1:0];

  always_comb begin
    case (op_i)
      e_op_beq:   taken = (opd_a_i == opd_b_i);
      e_op_bne:   taken = (opd_a_i != opd_b_i);
      e_op_blt:   taken = (opd_a_i < opd_b_i);
      // All masked flags set
      e_op_bfand: taken = (masked_flags == flag_mask);
      // Any masked flag set
      e_op_bfor:  taken = |masked_flags;
      default:    taken = 1'b0;
    endcase
  end

  // Predicted not taken, so only a taken branch redirects
  assign mispredict_o  = ex_v_i && taken;
  assign redirect_pc_o = taken ? branch_target : ex_pc_i + 1'b1;

endmodule

//--- hdl/cce_defs.svh
////////////////////////////////////////
// CCE widths and depths
// Microcode store, registers, pending table
////////////////////////////////////////
`ifndef CCE_DEFS_SVH
`define CCE_DEFS_SVH

// Microcode store and instruction format
`define CCE_PC_W       6
`define CCE_INSTR_W    26
`define CCE_OP_W       4

// Register file
`define CCE_GPR_W      16
`define CCE_GPR_SEL_W  2
`define CCE_NUM_GPR    4
`define CCE_NUM_FLAGS  4

// Pending bit table
`define CCE_WAY_GROUPS 16
`define CCE_WG_W       4

`endif

//--- hdl/cce_inst_decode.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE instruction decode
// Fetch to execute register, field split
////////////////////////////////////////
`include "cce_defs.svh"

module cce_inst_decode
  import cce_pkg::*;
  (
  input  logic         clk_i,
  input  logic         reset_i,
  input  cce_instr_t   fetch_inst_i,
  input  cce_pc_t      fetch_pc_i,
  input  logic         fetch_v_i,
  input  logic         stall_i,
  input  logic         mispredict_i,
  output cce_op_e      op_o,
  output cce_gpr_sel_t rd_o,
  output cce_gpr_sel_t ra_o,
  output cce_gpr_sel_t rb_o,
  output cce_gpr_t     imm_o,
  output cce_pc_t      ex_pc_o,
  output logic         ex_v_o
  );

  // Field positions below the opcode
  localparam int rd_lsb_lp = `CCE_INSTR_W - `CCE_OP_W - `CCE_GPR_SEL_W;
  localparam int ra_lsb_lp = rd_lsb_lp - `CCE_GPR_SEL_W;
  localparam int rb_lsb_lp = ra_lsb_lp - `CCE_GPR_SEL_W;

  cce_instr_t            inst_r;
  cce_pc_t               pc_r;
  logic                  v_r;
  logic [`CCE_OP_W-1:0]  op_raw;
  logic                  op_legal;

  // Valid bit, squashed on a taken branch
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (mispredict_i) begin
      v_r <= 1'b0;
    end else if (!stall_i) begin
      v_r <= fetch_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_r <= fetch_inst_i;
      pc_r   <= fetch_pc_i;
    end
  end

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////
  assign op_raw   = inst_r[`CCE_INSTR_W-1 -: `CCE_OP_W];
  // Only the top encoding is unused
  assign op_legal = (op_raw <= e_op_send);

  assign op_o    = op_legal ? cce_op_e'(op_raw) : e_op_nop;
  assign rd_o    = inst_r[rd_lsb_lp +: `CCE_GPR_SEL_W];
  assign ra_o    = inst_r[ra_lsb_lp +: `CCE_GPR_SEL_W];
  assign rb_o    = inst_r[rb_lsb_lp +: `CCE_GPR_SEL_W];
  assign imm_o   = inst_r[`CCE_GPR_W-1:0];
  assign ex_pc_o = pc_r;
  assign ex_v_o  = v_r && op_legal;

endmodule

//--- hdl/cce_inst_ram.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE microcode RAM and fetch stage
// Config load and readback, fetch PC,
// JMP predecode
////////////////////////////////////////
`include "cce_defs.svh"

module cce_inst_ram
  import cce_pkg::*;
  (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       cfg_run_i,
  input  logic       cfg_ucode_w_v_i,
  input  logic       cfg_ucode_r_v_i,
  input  cce_pc_t    cfg_ucode_addr_i,
  input  cce_instr_t cfg_ucode_data_i,
  input  logic       stall_i,
  input  logic       mispredict_i,
  input  cce_pc_t    redirect_pc_i,
  output cce_instr_t cfg_ucode_data_o,
  output cce_instr_t fetch_inst_o,
  output cce_pc_t    fetch_pc_o,
  output logic       fetch_v_o
  );

  cce_instr_t ucode_mem [2**`CCE_PC_W];
  cce_instr_t inst_r;
  cce_instr_t cfg_data_r;
  cce_pc_t    pc_r;
  cce_pc_t    fetch_pc_r;
  logic       fetch_v_r;
  logic       fetch_jmp;
  cce_pc_t    jmp_target;

  ////////////////////////////////////////
  // Configuration access
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (cfg_ucode_w_v_i) begin
      ucode_mem[cfg_ucode_addr_i] <= cfg_ucode_data_i;
    end
  end

  // Readback data lands one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_data_r <= '0;
    end else if (cfg_ucode_r_v_i) begin
      cfg_data_r <= ucode_mem[cfg_ucode_addr_i];
    end
  end

  ////////////////////////////////////////
  // Fetch and predecode
  ////////////////////////////////////////
  assign fetch_jmp  = fetch_v_r &&
                      (cce_op_e'(inst_r[`CCE_INSTR_W-1 -: `CCE_OP_W]) == e_op_jmp);
  assign jmp_target = inst_r[`CCE_PC_W-1:0];

  // Synchronous read, held while stalled
  always_ff @(posedge clk_i) begin
    if (cfg_run_i && !stall_i) begin
      inst_r     <= ucode_mem[pc_r];
      fetch_pc_r <= pc_r;
    end
  end

  // PC parks at 0 while halted
  always_ff @(posedge clk_i) begin
    if (reset_i || !cfg_run_i) begin
      pc_r      <= '0;
      fetch_v_r <= 1'b0;
    end else if (mispredict_i) begin
      pc_r      <= redirect_pc_i;
      fetch_v_r <= 1'b0;
    end else if (!stall_i) begin
      // A JMP in fetch drops the word read behind it
      pc_r      <= fetch_jmp ? jmp_target : pc_r + 1'b1;
      fetch_v_r <= !fetch_jmp;
    end
  end

  assign cfg_ucode_data_o = cfg_data_r;
  assign fetch_inst_o     = inst_r;
  assign fetch_pc_o       = fetch_pc_r;
  assign fetch_v_o        = fetch_v_r;

  // Microcode only changes while the engine is halted
  a_no_write_running: assert property (@(posedge clk_i) disable iff (reset_i)
    cfg_ucode_w_v_i |-> !cfg_run_i);

endmodule

//--- hdl/cce_msg.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE message unit
// LCE request pop, memory command send,
// stall generation
////////////////////////////////////////

module cce_msg
  import cce_pkg::*;
  (
  input  logic     clk_i,
  input  logic     reset_i,
  input  cce_op_e  op_i,
  input  logic     ex_v_i,
  input  cce_gpr_t opd_a_i,
  input  cce_gpr_t opd_b_i,
  input  logic     lce_req_v_i,
  input  logic     mem_cmd_ready_i,
  output logic     stall_o,
  output logic     lce_req_yumi_o,
  output logic     mem_cmd_v_o,
  output cce_gpr_t mem_cmd_addr_o,
  output cce_gpr_t mem_cmd_data_o
  );

  logic popq_v;
  logic send_v;

  assign popq_v = ex_v_i && (op_i == e_op_popq);
  assign send_v = ex_v_i && (op_i == e_op_send);

  ////////////////////////////////////////
  // Stall and strobes
  ////////////////////////////////////////
  // Wait for a request or for the memory side
  assign stall_o = (popq_v && !lce_req_v_i) || (send_v && !mem_cmd_ready_i);

  // Request consumed in the cycle it is seen
  assign lce_req_yumi_o = popq_v && lce_req_v_i;

  // Address from ra, data from rb
  assign mem_cmd_v_o    = send_v;
  assign mem_cmd_addr_o = opd_a_i;
  assign mem_cmd_data_o = opd_b_i;

  // Pipeline hold keeps the command steady until accepted
  a_mem_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cmd_v_o && !mem_cmd_ready_i) |=>
      (mem_cmd_v_o && $stable(mem_cmd_addr_o) && $stable(mem_cmd_data_o)));

endmodule

//--- hdl/cce_pending_bits.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE pending bit table
// One bit per way group
////////////////////////////////////////
`include "cce_defs.svh"

module cce_pending_bits
  import cce_pkg::*;
  (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    w_v_i,
  input  cce_wg_t wg_i,
  input  logic    pending_i,
  output logic    pending_o
  );

  logic [`CCE_WAY_GROUPS-1:0] pending_r;

  // Write at end of execute cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= '0;
    end else if (w_v_i) begin
      pending_r[wg_i] <= pending_i;
    end
  end

  // Combinational read, same way group as the write
  assign pending_o = pending_r[wg_i];

endmodule

//--- hdl/cce_pkg.sv
////////////////////////////////////////
// CCE shared types
// Vector typedefs and microcode encodings
////////////////////////////////////////
`include "cce_defs.svh"

package cce_pkg;

  typedef logic [`CCE_PC_W-1:0]      cce_pc_t;
  typedef logic [`CCE_INSTR_W-1:0]   cce_instr_t;
  typedef logic [`CCE_GPR_W-1:0]     cce_gpr_t;
  typedef logic [`CCE_GPR_SEL_W-1:0] cce_gpr_sel_t;
  typedef logic [`CCE_NUM_FLAGS-1:0] cce_flags_t;
  typedef logic [`CCE_WG_W-1:0]      cce_wg_t;

  // Microcode opcodes, 4'hf left unassigned
  typedef enum logic [`CCE_OP_W-1:0] {
    e_op_nop   = 4'h0,
    e_op_movi  = 4'h1,
    e_op_add   = 4'h2,
    e_op_sub   = 4'h3,
    e_op_beq   = 4'h4,
    e_op_bne   = 4'h5,
    e_op_blt   = 4'h6,
    e_op_jmp   = 4'h7,
    e_op_bfand = 4'h8,
    e_op_bfor  = 4'h9,
    e_op_wflg  = 4'ha,
    e_op_wdp   = 4'hb,
    e_op_rdp   = 4'hc,
    e_op_popq  = 4'hd,
    e_op_send  = 4'he
  } cce_op_e;

  // ALU functions
  typedef enum logic [1:0] {
    e_alu_add    = 2'd0,
    e_alu_sub    = 2'd1,
    e_alu_pass_b = 2'd2
  } cce_alu_op_e;

endpackage

//--- hdl/cce_reg_file.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE register file
// Four GPRs and the flags register
////////////////////////////////////////
`include "cce_defs.svh"

module cce_reg_file
  import cce_pkg::*;
  (
  input  logic         clk_i,
  input  logic         reset_i,
  input  cce_op_e      op_i,
  input  logic         ex_v_i,
  input  logic         stall_i,
  input  cce_gpr_sel_t rd_i,
  input  cce_gpr_sel_t ra_i,
  input  cce_gpr_sel_t rb_i,
  input  cce_gpr_t     imm_i,
  input  cce_gpr_t     alu_res_i,
  input  cce_gpr_t     lce_req_addr_i,
  input  logic         pending_i,
  output cce_gpr_t     opd_a_o,
  output cce_gpr_t     opd_b_o,
  output cce_flags_t   flags_o
  );

  cce_gpr_t   gpr_r [`CCE_NUM_GPR];
  cce_flags_t flags_r;
  logic       ex_go;
  logic       gpr_w_v;
  cce_gpr_t   gpr_w_data;

  assign ex_go = ex_v_i && !stall_i;

  // Write source select
  always_comb begin
    gpr_w_v    = 1'b0;
    gpr_w_data = alu_res_i;
    case (op_i)
      e_op_movi: begin
        gpr_w_v    = ex_go;
        gpr_w_data = imm_i;
      end
      e_op_add, e_op_sub: gpr_w_v = ex_go;
      // Request address captured in the pop cycle
      e_op_popq: begin
        gpr_w_v    = ex_go;
        gpr_w_data = lce_req_addr_i;
      end
      default: gpr_w_v = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `CCE_NUM_GPR; i++) begin
        gpr_r[i] <= '0;
      end
    end else if (gpr_w_v) begin
      gpr_r[rd_i] <= gpr_w_data;
    end
  end

  // Flags from WFLG, flag 0 from RDP
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flags_r <= '0;
    end else if (ex_go && (op_i == e_op_wflg)) begin
      flags_r <= imm_i[`CCE_NUM_FLAGS-1:0];
    end else if (ex_go && (op_i == e_op_rdp)) begin
      flags_r[0] <= pending_i;
    end
  end

  assign opd_a_o = gpr_r[ra_i];
  assign opd_b_o = gpr_r[rb_i];
  assign flags_o = flags_r;

endmodule

//--- verif/cce_input.dat
// Each entry is tag_payload. Tag 1 microcode word in address order, 2 LCE request address,
// 3 expected memory command {addr, data}, 4 same for pending bit results, 0 end of list
// Requests, arithmetic, first sends (PC 0-6)
1_03400000 1_00500100 1_00a10000 1_03820000 1_03500000 1_00f40000 1_03870000
// BLT not taken, JMP, BLT taken (PC 7-15)
1_0181000a 1_006000b1 1_01c0000b 1_006000b2 1_03820000
1_0184000f 1_00600bad 1_00700bad 1_03860000
// BEQ taken, BNE not taken (PC 16-21)
1_01000013 1_00600bad 1_038a0000 1_01400016 1_006000c3 1_03820000
// BFAND not taken and taken (PC 22-28)
1_0280000c 1_02000017 1_006000d1 1_0200001c 1_00600bad 1_038a0000 1_03820000
// BFOR not taken and taken (PC 29-35)
1_02800001 1_0240001e 1_006000e1 1_02400023 1_00600bad 1_00600bad 1_03860000
// Pending bit set, read through BFOR (PC 36-44)
1_03700000 1_02cc0001 1_02800000 1_030c0000 1_0240002b
1_00600f00 1_01c0002c 1_00600f01 1_038e0000
// Pending bit cleared and read again, then park (PC 45-50)
1_02cc0000 1_030c0000 1_02400031 1_00600f10 1_038e0000 1_01c00032
// LCE request addresses
2_00001234 2_00000a50 2_000000f3
// Expected memory commands in order
3_12341334 3_0a50f81c 3_123400b1 3_0a5000b1 3_123400c3 3_123400d1 3_0a5000e1
4_00f30f01 4_00f30f10
0_00000000

//--- verif/cce_tb.sv
`timescale 1ns/1ps
////////////////////////////////////////
// CCE testbench
// Loads microcode from the data file, runs it
// against LCE requests and checks memory commands
////////////////////////////////////////
`include "cce_defs.svh"

module cce_tb
  import cce_pkg::*;
  ();

  localparam int num_tests_lp   = 6;
  localparam int stim_depth_lp  = 128;
  localparam int timeout_lp     = 2000;
  localparam int idle_cycles_lp = 30;

  logic         clk = 1'b0;
  logic         reset;
  logic         cfg_run;
  logic         cfg_ucode_w_v;
  logic         cfg_ucode_r_v;
  cce_pc_t      cfg_ucode_addr;
  cce_instr_t   cfg_ucode_wdata;
  cce_instr_t   cfg_ucode_rdata;
  logic         lce_req_v;
  cce_gpr_t     lce_req_addr;
  logic         lce_req_yumi;
  logic         mem_cmd_v;
  cce_gpr_t     mem_cmd_addr;
  cce_gpr_t     mem_cmd_data;
  logic         mem_cmd_ready;

  // Entry is {tag, payload}
  logic [35:0]  stim_mem [stim_depth_lp];
  cce_instr_t   ucode_q [$];
  cce_gpr_t     req_q [$];
  logic [31:0]  exp_cmd_q [$];
  logic         exp_pend_q [$];
  int           test_errs [num_tests_lp];
  int           tests_failed;

  always #10 clk = ~clk;

  cce i_cce (
    .clk_i            (clk),
    .reset_i          (reset),
    .cfg_run_i        (cfg_run),
    .cfg_ucode_w_v_i  (cfg_ucode_w_v),
    .cfg_ucode_r_v_i  (cfg_ucode_r_v),
    .cfg_ucode_addr_i (cfg_ucode_addr),
    .cfg_ucode_data_i (cfg_ucode_wdata),
    .cfg_ucode_data_o (cfg_ucode_rdata),
    .lce_req_v_i      (lce_req_v),
    .lce_req_addr_i   (lce_req_addr),
    .lce_req_yumi_o   (lce_req_yumi),
    .mem_cmd_v_o      (mem_cmd_v),
    .mem_cmd_addr_o   (mem_cmd_addr),
    .mem_cmd_data_o   (mem_cmd_data),
    .mem_cmd_ready_i  (mem_cmd_ready)
  );

  ////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////
  task automatic check_value(input int test_id, input string sig_name,
                             input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", sig_name, got, exp);
      test_errs[test_id]++;
    end
  endtask

  task automatic check_true(input int test_id, input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR: %s", what);
      test_errs[test_id]++;
    end
  endtask

  function automatic string test_name(input int test_id);
    case (test_id)
      0:       return "reset values";
      1:       return "microcode readback";
      2:       return "request acknowledge";
      3:       return "memory command stream";
      4:       return "pending bit results";
      default: return "command back-pressure";
    endcase
  endfunction

  task automatic report_test(input int test_id);
    if (test_errs[test_id] == 0) begin
      $display("test %0d (%s) passed", test_id + 1, test_name(test_id));
    end else begin
      $display("test %0d (%s) failed with %0d errors", test_id + 1,
               test_name(test_id), test_errs[test_id]);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////
  task automatic load_stimulus();
    logic [3:0]  tag;
    logic [31:0] payload;
    logic        done;
    for (int i = 0; i < stim_depth_lp; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verif/cce_input.dat", stim_mem);
    done = 1'b0;
    for (int i = 0; i < stim_depth_lp && !done; i++) begin
      tag     = stim_mem[i][35:32];
      payload = stim_mem[i][31:0];
      case (tag)
        4'h0: done = 1'b1;
        4'h1: ucode_q.push_back(payload[`CCE_INSTR_W-1:0]);
        4'h2: req_q.push_back(payload[`CCE_GPR_W-1:0]);
        4'h3, 4'h4: begin
          exp_cmd_q.push_back(payload);
          exp_pend_q.push_back(tag == 4'h4);
        end
        default: check_true(1, 1'b0, $sformatf("unknown tag %0h in data file", tag));
      endcase
    end
    check_true(1, ucode_q.size() <= 2**`CCE_PC_W, "microcode larger than the RAM");
  endtask

  task automatic load_ucode();
    for (int a = 0; a < ucode_q.size(); a++) begin
      @(posedge clk);
      cfg_ucode_w_v   <= 1'b1;
      cfg_ucode_addr  <= cce_pc_t'(a);
      cfg_ucode_wdata <= ucode_q[a];
    end
    @(posedge clk);
    cfg_ucode_w_v <= 1'b0;
  endtask

  // Read data arrives the cycle after the strobe
  task automatic read_back_ucode();
    for (int a = 0; a < ucode_q.size(); a++) begin
      @(posedge clk);
      cfg_ucode_r_v  <= 1'b1;
      cfg_ucode_addr <= cce_pc_t'(a);
      @(posedge clk);
      cfg_ucode_r_v  <= 1'b0;
      @(negedge clk);
      check_value(1, "cfg_ucode_data_o", 32'(cfg_ucode_rdata), 32'(ucode_q[a]));
    end
  endtask

  ////////////////////////////////////////
  // LCE request source and memory sink
  ////////////////////////////////////////
  task automatic drive_requests();
    int   gap;
    int   wait_cycles;
    logic acked;
    foreach (req_q[i]) begin
      gap = $urandom_range(0, 6);
      repeat (gap) @(posedge clk);
      @(posedge clk);
      lce_req_v    <= 1'b1;
      lce_req_addr <= req_q[i];
      acked       = 1'b0;
      wait_cycles = 0;
      while (!acked && wait_cycles < timeout_lp) begin
        @(negedge clk);
        wait_cycles++;
        acked = lce_req_yumi;
      end
      check_true(2, acked, $sformatf("request %0d was never acknowledged", i));
      // Consumed at this edge
      @(posedge clk);
      lce_req_v <= 1'b0;
    end
  endtask

  // Random low periods on ready
  task automatic drive_ready();
    int low_len;
    int high_len;
    forever begin
      low_len  = $urandom_range(0, 3);
      high_len = $urandom_range(1, 2);
      repeat (low_len) begin
        @(posedge clk);
        mem_cmd_ready <= 1'b0;
      end
      repeat (high_len) begin
        @(posedge clk);
        mem_cmd_ready <= 1'b1;
      end
    end
  endtask

  task automatic watch_mem_cmds();
    int       idx;
    int       wait_cycles;
    int       tid;
    logic     holding;
    cce_gpr_t held_addr;
    cce_gpr_t held_data;
    idx         = 0;
    wait_cycles = 0;
    holding     = 1'b0;
    held_addr   = '0;
    held_data   = '0;
    while (idx < exp_cmd_q.size() && wait_cycles < timeout_lp) begin
      @(negedge clk);
      wait_cycles++;
      if (mem_cmd_v) begin
        if (holding) begin
          check_value(5, "mem_cmd_addr_o", 32'(mem_cmd_addr), 32'(held_addr));
          check_value(5, "mem_cmd_data_o", 32'(mem_cmd_data), 32'(held_data));
        end else begin
          tid = exp_pend_q[idx] ? 4 : 3;
          check_value(tid, "mem_cmd_addr_o", 32'(mem_cmd_addr), 32'(exp_cmd_q[idx][31:16]));
          check_value(tid, "mem_cmd_data_o", 32'(mem_cmd_data), 32'(exp_cmd_q[idx][15:0]));
          held_addr = mem_cmd_addr;
          held_data = mem_cmd_data;
          holding   = 1'b1;
        end
        // Transfer at the coming edge
        if (mem_cmd_ready) begin
          holding     = 1'b0;
          wait_cycles = 0;
          idx++;
        end
      end else begin
        check_true(5, !holding, "mem_cmd_v_o dropped before the transfer");
        holding = 1'b0;
      end
    end
    check_true(3, idx == exp_cmd_q.size(), "timed out waiting for a memory command");
    repeat (idle_cycles_lp) begin
      @(negedge clk);
      check_true(5, !mem_cmd_v, "memory command beyond the expected list");
    end
  endtask

  // Yumi only while a request is offered
  always @(negedge clk) begin
    if (cfg_run) begin
      check_true(2, !(lce_req_yumi && !lce_req_v), "yumi pulse without a request");
    end
  end

  initial begin : watchdog
    #1000000;
    $display("ERROR: watchdog expired before the end of the run");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin : main
    reset           = 1'b1;
    cfg_run         = 1'b0;
    cfg_ucode_w_v   = 1'b0;
    cfg_ucode_r_v   = 1'b0;
    cfg_ucode_addr  = '0;
    cfg_ucode_wdata = '0;
    lce_req_v       = 1'b0;
    lce_req_addr    = '0;
    mem_cmd_ready   = 1'b0;
    tests_failed    = 0;
    for (int i = 0; i < num_tests_lp; i++) begin
      test_errs[i] = 0;
    end
    void'($urandom(90503));
    load_stimulus();

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value(0, "mem_cmd_v_o", 32'(mem_cmd_v), 32'h0);
    check_value(0, "lce_req_yumi_o", 32'(lce_req_yumi), 32'h0);
    check_value(0, "cfg_ucode_data_o", 32'(cfg_ucode_rdata), 32'h0);
    report_test(0);

    load_ucode();
    read_back_ucode();
    report_test(1);

    fork
      drive_ready();
    join_none
    @(posedge clk);
    cfg_run <= 1'b1;
    fork
      drive_requests();
      watch_mem_cmds();
    join
    for (int i = 2; i < num_tests_lp; i++) begin
      report_test(i);
    end

    $display("%0d tests, %0d passed, %0d failed", num_tests_lp,
             num_tests_lp - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/cce_pkg.sv
hdl/cce_inst_ram.sv
hdl/cce_inst_decode.sv
hdl/cce_alu_branch.sv
hdl/cce_reg_file.sv
hdl/cce_pending_bits.sv
hdl/cce_msg.sv
hdl/cce.sv
verif/cce_tb.sv
